/* fetch_unit.f */
src/fetch_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f fetch_unit.f -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if grep -qx "Test completed successfully" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* tb/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  typedef enum logic [1:0] {LOADS_ANY, LOADS_NONE, LOADS_SOME} load_chk_e;

  typedef struct packed {
    logic           redirect;
    fetch_pkg::pc_t pc;
    logic [7:0]     count;       // Instructions to receive
    logic           rdy_random;
    load_chk_e      loads;
  } stim_t;

  stim_t stim [9] = '{
    '{1'b0, 16'h0000, 8'd16, 1'b0, LOADS_ANY},   // Stream from reset
    '{1'b1, 16'h0008, 8'd4,  1'b0, LOADS_NONE},  // Back to a filled line
    '{1'b1, 16'h0014, 8'd5,  1'b0, LOADS_ANY},   // Upper word first
    '{1'b0, 16'h0000, 8'd24, 1'b1, LOADS_ANY},
    '{1'b1, 16'h0280, 8'd1,  1'b1, LOADS_ANY},
    '{1'b1, 16'h0344, 8'd8,  1'b1, LOADS_ANY},   // Likely over a pending miss
    '{1'b1, 16'h1008, 8'd4,  1'b0, LOADS_SOME},  // Same index, new tag
    '{1'b1, 16'h0008, 8'd4,  1'b1, LOADS_SOME},
    '{1'b0, 16'h0000, 8'd10, 1'b1, LOADS_ANY}
  };

  logic                   clock = 1'b0;
  logic                   rst_n;
  fetch_pkg::mem_tag_t    mem2proc_response;
  fetch_pkg::line_t       mem2proc_data;
  fetch_pkg::mem_tag_t    mem2proc_tag;
  logic                   redirect_en;
  fetch_pkg::pc_t         redirect_pc;
  logic                   inst_ready;
  fetch_pkg::bus_cmd_e    proc2mem_command;
  fetch_pkg::pc_t         proc2mem_addr;
  fetch_pkg::fetch_inst_t inst_out;
  logic                   inst_valid;

  logic                   ready_random;
  logic                   accept_bit;
  fetch_pkg::mem_tag_t    next_tag;
  logic [31:0]            lfsr_q = 32'h9a97;
  int                     xfer_count;
  int                     load_count;
  int                     error_count;

  always #20 clock = ~clock;

  fetch_top u_fetch_top (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .inst_ready        (inst_ready),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .inst_out          (inst_out),
    .inst_valid        (inst_valid)
  );

  fetch_checker u_checker (
    .clock            (clock),
    .rst_n            (rst_n),
    .inst_valid       (inst_valid),
    .inst_ready       (inst_ready),
    .redirect_en      (redirect_en),
    .redirect_pc      (redirect_pc),
    .inst_out         (inst_out),
    .proc2mem_command (proc2mem_command),
    .proc2mem_addr    (proc2mem_addr),
    .xfer_count       (xfer_count),
    .load_count       (load_count),
    .error_count      (error_count)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[6:0], lfsr_q[0]};
    end
  endtask

  // Lower word holds the lower address
  function automatic fetch_pkg::line_t mem_line(input fetch_pkg::pc_t base);
    return {16'hA5C3, base + 16'd4, 16'hA5C3, base};
  endfunction

  task automatic wait_transfers(input int target, output logic ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
      if (xfer_count >= target) begin
        ok = 1'b1;
        break;
      end
      @(posedge clock);
      #2;
    end
  endtask

  assign mem2proc_response = (proc2mem_command == fetch_pkg::BUS_LOAD && accept_bit) ?
                             next_tag : '0;

  // Memory model and consumer ready
  initial begin
    logic                took;
    fetch_pkg::pc_t      took_addr;
    fetch_pkg::mem_tag_t took_tag;
    logic                rdy_mode;
    logic                pend_valid;
    logic [2:0]          pend_cnt;
    fetch_pkg::mem_tag_t pend_tag;
    fetch_pkg::pc_t      pend_addr;
    logic [7:0]          bits;
    mem2proc_tag  = '0;
    mem2proc_data = '0;
    inst_ready    = 1'b0;
    accept_bit    = 1'b0;
    next_tag      = 4'd1;
    pend_valid    = 1'b0;
    pend_cnt      = '0;
    pend_tag      = '0;
    pend_addr     = '0;
    forever begin
      @(posedge clock);
      took      = (proc2mem_command == fetch_pkg::BUS_LOAD) && (mem2proc_response != '0);
      took_addr = proc2mem_addr;
      took_tag  = mem2proc_response;
      rdy_mode  = ready_random;
      #2;
      if (took) begin
        draw_bits(3, bits);
        pend_valid = 1'b1;
        pend_cnt   = bits[2:0];  // Latency 1 to 8
        pend_tag   = took_tag;
        pend_addr  = took_addr;
        next_tag   = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      mem2proc_tag = '0;
      if (pend_valid) begin
        if (pend_cnt == 3'd0) begin
          mem2proc_tag  = pend_tag;
          mem2proc_data = mem_line(pend_addr);
          pend_valid    = 1'b0;
        end else begin
          pend_cnt = pend_cnt - 3'd1;
        end
      end
      draw_bits(1, bits);
      accept_bit = bits[0];
      if (rdy_mode) begin
        draw_bits(1, bits);
        inst_ready = bits[0];
      end else begin
        inst_ready = 1'b1;
      end
    end
  end

  initial begin
    int   xfer_base;
    int   load_base;
    int   err_base;
    int   loads;
    int   got;
    int   tests_run;
    int   tests_failed;
    int   assert_fails;
    logic ok;
    logic test_ok;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    redirect_en  = 1'b0;
    redirect_pc  = fetch_pkg::RESET_PC;
    ready_random = 1'b0;
    repeat (3) @(posedge clock);
    #2;
    rst_n = 1'b1;

    for (int r = 0; r < $size(stim); r++) begin
      ready_random = stim[r].rdy_random;
      if (stim[r].redirect) begin
        redirect_en = 1'b1;
        redirect_pc = stim[r].pc;
        @(posedge clock);
        #2;
        redirect_en = 1'b0;
      end
      xfer_base = xfer_count;
      load_base = load_count;
      err_base  = error_count;
      wait_transfers(xfer_base + int'(stim[r].count), ok);
      got     = xfer_count - xfer_base;
      loads   = load_count - load_base;
      test_ok = ok && (error_count == err_base);
      if (!ok) begin
        $display("test %0d: timed out waiting for instructions", r);
      end
      if (stim[r].loads == LOADS_NONE && loads != 0) begin
        $display("test %0d: expected no memory requests but saw %0d", r, loads);
        test_ok = 1'b0;
      end
      if (stim[r].loads == LOADS_SOME && loads == 0) begin
        $display("test %0d: expected a memory request but saw none", r);
        test_ok = 1'b0;
      end
      tests_run++;
      if (!test_ok) begin
        tests_failed++;
      end
      $display("test %0d: redirect=%0b pc=%h recv %0d/%0d loads %0d %s", r, stim[r].redirect,
               stim[r].pc, got, stim[r].count, loads, test_ok ? "ok" : "FAIL");
      if (!ok) begin
        break;  // Later rows rely on an intact stream
      end
    end

    assert_fails = u_fetch_top.u_fetch_assertions.fail_count;
    $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures", tests_run,
             tests_failed, error_count, assert_fails);
    if (tests_failed == 0 && error_count == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  logic                   inst_ready,
  input  logic                   redirect_en,
  input  fetch_pkg::pc_t         redirect_pc,
  input  fetch_pkg::fetch_inst_t inst_out,
  input  fetch_pkg::bus_cmd_e    proc2mem_command,
  input  fetch_pkg::pc_t         proc2mem_addr,
  output int                     xfer_count,
  output int                     load_count,
  output int                     error_count
);

  fetch_pkg::pc_t   exp_pc;
  fetch_pkg::inst_t exp_ir;

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc      = fetch_pkg::RESET_PC;
      xfer_count  = 0;
      load_count  = 0;
      error_count = 0;
    end else begin
      if (proc2mem_command == fetch_pkg::BUS_LOAD) begin
        load_count++;
        if (proc2mem_addr[fetch_pkg::OFFSET_W-1:0] !== 3'h0) begin  // Line aligned
          $display("ERR proc2mem_addr[2:0] got %h expected %h",
                   proc2mem_addr[fetch_pkg::OFFSET_W-1:0], 3'h0);
          error_count++;
        end
      end
      if (inst_valid && inst_ready) begin
        exp_ir = {16'hA5C3, exp_pc};  // Memory rule
        if (inst_out.pc !== exp_pc) begin
          $display("ERR inst_out.pc got %h expected %h", inst_out.pc, exp_pc);
          error_count++;
        end
        if (inst_out.ir !== exp_ir) begin
          $display("ERR inst_out.ir got %h expected %h", inst_out.ir, exp_ir);
          error_count++;
        end
        xfer_count++;
        exp_pc = exp_pc + 16'd4;
      end
      // Same-cycle transfer was still the old stream
      if (redirect_en) begin
        exp_pc = redirect_pc;
      end
    end
  end

endmodule

/* tb/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
  input logic                   clock,
  input logic                   rst_n,
  input logic                   inst_valid,
  input logic                   inst_ready,
  input logic                   redirect_en,
  input fetch_pkg::fetch_inst_t inst_out,
  input fetch_pkg::bus_cmd_e    proc2mem_command
);

  int fail_count = 0;

  a_reset_quiet: assert property (@(posedge clock)
      !rst_n |-> !inst_valid && (proc2mem_command == fetch_pkg::BUS_NONE))
    else begin
      fail_count++;
      $error("inst_valid or memory request active during reset");
    end

  // Stalled head entry must not move
  a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
      inst_valid && !inst_ready && !redirect_en |=> inst_valid && $stable(inst_out))
    else begin
      fail_count++;
      $error("inst_out changed while stalled");
    end

  a_flush_empty: assert property (@(posedge clock) disable iff (!rst_n)
      redirect_en |=> !inst_valid)
    else begin
      fail_count++;
      $error("inst_valid high in the cycle after a redirect");
    end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
  .clock            (clock),
  .rst_n            (rst_n),
  .inst_valid       (inst_valid),
  .inst_ready       (inst_ready),
  .redirect_en      (redirect_en),
  .inst_out         (inst_out),
  .proc2mem_command (proc2mem_command)
);

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clock,
  input  logic                   rst_n,
  input  fetch_pkg::mem_tag_t    mem2proc_response,
  input  fetch_pkg::line_t       mem2proc_data,
  input  fetch_pkg::mem_tag_t    mem2proc_tag,
  input  logic                   redirect_en,
  input  fetch_pkg::pc_t         redirect_pc,
  input  logic                   inst_ready,
  output fetch_pkg::bus_cmd_e    proc2mem_command,
  output fetch_pkg::pc_t         proc2mem_addr,
  output fetch_pkg::fetch_inst_t inst_out,
  output logic                   inst_valid
);

  fetch_pkg::pc_t        fetch_addr;
  fetch_pkg::line_t      line;
  fetch_pkg::icache_wr_t fill;
  fetch_pkg::fb_push_t   push;
  logic                  hit;
  logic                  fetch_en;

  fetch_stage u_fetch_stage (
    .clock       (clock),
    .rst_n       (rst_n),
    .hit         (hit),
    .line        (line),
    .fetch_en    (fetch_en),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .push        (push)
  );

  icache_ctrl u_icache_ctrl (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_addr        (fetch_addr),
    .hit               (hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill              (fill)
  );

  icache_mem u_icache_mem (
    .clock      (clock),
    .rst_n      (rst_n),
    .fetch_addr (fetch_addr),
    .fill       (fill),
    .hit        (hit),
    .line       (line)
  );

  fetch_buffer u_fetch_buffer (
    .clock       (clock),
    .rst_n       (rst_n),
    .push        (push),
    .inst_ready  (inst_ready),
    .redirect_en (redirect_en),
    .fetch_en    (fetch_en),
    .inst_out    (inst_out),
    .inst_valid  (inst_valid)
  );

endmodule

/* src/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer (
  input  logic                   clock,
  input  logic                   rst_n,
  input  fetch_pkg::fb_push_t    push,
  input  logic                   inst_ready,
  input  logic                   redirect_en,   // Flushes all entries
  output logic                   fetch_en,
  output fetch_pkg::fetch_inst_t inst_out,
  output logic                   inst_valid
);

  typedef logic [$clog2(fetch_pkg::FB_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(fetch_pkg::FB_DEPTH+1)-1:0] cnt_t;

  fetch_pkg::fetch_inst_t entries [fetch_pkg::FB_DEPTH];

  ptr_t head_q;
  ptr_t tail_q;
  ptr_t tail_plus1;
  cnt_t count_q;
  logic pop;
  logic wr0;
  logic wr1;

  assign inst_valid = (count_q != '0);
  assign inst_out   = entries[head_q];
  assign pop        = inst_valid && inst_ready;

  // Two free entries needed for a full line
  assign fetch_en = (count_q <= cnt_t'(fetch_pkg::FB_DEPTH - 2));

  assign tail_plus1 = tail_q + ptr_t'(1);
  assign wr0        = !redirect_en && (push.count != 2'd0);
  assign wr1        = !redirect_en && (push.count == 2'd2);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (redirect_en) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (pop) begin
        head_q <= head_q + ptr_t'(1);
      end
      tail_q  <= tail_q + ptr_t'(push.count);
      count_q <= count_q + cnt_t'(push.count) - cnt_t'(pop);
    end
  end

  // Pushes only land in free slots, so the head entry holds
  always_ff @(posedge clock) begin
    if (wr0) begin
      entries[tail_q] <= push.slot[0];
    end
    if (wr1) begin
      entries[tail_plus1] <= push.slot[1];
    end
  end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                hit,
  input  fetch_pkg::line_t    line,
  input  logic                fetch_en,      // Room for two in the buffer
  input  logic                redirect_en,
  input  fetch_pkg::pc_t      redirect_pc,
  output fetch_pkg::pc_t      fetch_addr,
  output fetch_pkg::fb_push_t push
);

  fetch_pkg::pc_t pc_q;
  fetch_pkg::pc_t line_base;
  fetch_pkg::pc_t next_line_pc;
  logic           do_push;
  logic           upper_only;

  assign fetch_addr = pc_q;

  // PC in the upper word of the line yields a single instruction
  assign upper_only = pc_q[2];
  assign do_push    = hit && fetch_en && !redirect_en;

  assign line_base    = {pc_q[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W],
                         {fetch_pkg::OFFSET_W{1'b0}}};
  assign next_line_pc = line_base + fetch_pkg::pc_t'(1 << fetch_pkg::OFFSET_W);

  always_comb begin
    if (do_push) begin
      push.count = upper_only ? 2'd1 : 2'd2;
    end else begin
      push.count = 2'd0;
    end
    push.slot[0].pc = pc_q;
    push.slot[0].ir = upper_only ? line[fetch_pkg::LINE_W-1:fetch_pkg::INST_W]
                                 : line[fetch_pkg::INST_W-1:0];
    push.slot[1].pc = line_base + fetch_pkg::pc_t'(4);   // Upper word
    push.slot[1].ir = line[fetch_pkg::LINE_W-1:fetch_pkg::INST_W];
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else if (redirect_en) begin
      pc_q <= redirect_pc;
    end else if (do_push) begin
      pc_q <= next_line_pc;  // Sequential, no prediction
    end
  end

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                   clock,
  input  logic                   rst_n,
  input  fetch_pkg::pc_t         fetch_addr,
  input  logic                   hit,
  input  fetch_pkg::mem_tag_t    mem2proc_response,  // Nonzero accepts the request
  input  fetch_pkg::line_t       mem2proc_data,
  input  fetch_pkg::mem_tag_t    mem2proc_tag,       // Tag of returning data
  output fetch_pkg::bus_cmd_e    proc2mem_command,
  output fetch_pkg::pc_t         proc2mem_addr,
  output fetch_pkg::icache_wr_t  fill
);

  fetch_pkg::miss_state_e state_q;
  fetch_pkg::miss_state_e state_d;
  fetch_pkg::mem_tag_t    wait_tag_q;
  fetch_pkg::pc_t         req_addr_q;
  logic                   armed_q;
  logic                   req;
  logic                   accepted;
  logic                   returned;

  // No request in the first cycle out of reset
  assign req      = armed_q && (state_q == fetch_pkg::MISS_IDLE) && !hit;
  assign accepted = req && (mem2proc_response != '0);
  assign returned = (state_q == fetch_pkg::MISS_WAIT) && (mem2proc_tag == wait_tag_q);

  assign proc2mem_command = req ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
  assign proc2mem_addr    = {fetch_addr[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W],
                             {fetch_pkg::OFFSET_W{1'b0}}};  // Line base

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::MISS_IDLE: begin
        if (accepted) begin
          state_d = fetch_pkg::MISS_WAIT;
        end
      end
      fetch_pkg::MISS_WAIT: begin
        if (returned) begin
          state_d = fetch_pkg::MISS_IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::MISS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= fetch_pkg::MISS_IDLE;
      wait_tag_q <= '0;
      armed_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      armed_q <= 1'b1;
      if (accepted) begin
        wait_tag_q <= mem2proc_response;
      end
    end
  end

  // Fill target stays fixed even if the PC moves on a redirect
  always_ff @(posedge clock) begin
    if (accepted) begin
      req_addr_q <= proc2mem_addr;
    end
  end

  always_comb begin
    fill.en   = returned;
    fill.idx  = req_addr_q[fetch_pkg::OFFSET_W +: fetch_pkg::IDX_W];
    fill.tag  = req_addr_q[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
    fill.data = mem2proc_data;
  end

endmodule

/* src/icache_mem.sv */
`timescale 1ns/1ps

module icache_mem (
  input  logic                  clock,
  input  logic                  rst_n,
  input  fetch_pkg::pc_t        fetch_addr,   // Lookup address from fetch
  input  fetch_pkg::icache_wr_t fill,         // Line fill from controller
  output logic                  hit,
  output fetch_pkg::line_t      line
);

  logic [fetch_pkg::NUM_LINES-1:0] valid_q;
  fetch_pkg::cache_tag_t           tag_mem  [fetch_pkg::NUM_LINES];
  fetch_pkg::line_t                data_mem [fetch_pkg::NUM_LINES];

  fetch_pkg::cache_idx_t rd_idx;
  fetch_pkg::cache_tag_t rd_tag;

  // Address split: tag | index | offset
  assign rd_idx = fetch_addr[fetch_pkg::OFFSET_W +: fetch_pkg::IDX_W];
  assign rd_tag = fetch_addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];

  assign hit  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign line = data_mem[rd_idx];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill.en) begin
      valid_q[fill.idx] <= 1'b1;
    end
  end

  // Fill overwrites tag and data of the indexed line
  always_ff @(posedge clock) begin
    if (fill.en) begin
      tag_mem[fill.idx]  <= fill.tag;
      data_mem[fill.idx] <= fill.data;
    end
  end

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

  localparam int ADDR_W    = 16;
  localparam int INST_W    = 32;
  localparam int LINE_W    = 64;      // Two instructions per line
  localparam int OFFSET_W  = 3;
  localparam int IDX_W     = 5;
  localparam int TAG_W     = 8;
  localparam int NUM_LINES = 32;
  localparam int FB_DEPTH  = 8;
  localparam int MEM_TAG_W = 4;

  typedef logic [ADDR_W-1:0]    pc_t;
  typedef logic [INST_W-1:0]    inst_t;
  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [IDX_W-1:0]     cache_idx_t;
  typedef logic [TAG_W-1:0]     cache_tag_t;
  typedef logic [MEM_TAG_W-1:0] mem_tag_t;   // Zero means no transaction

  localparam pc_t RESET_PC = 16'h0000;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2   // Encoding only, no stores on this side
  } bus_cmd_e;

  typedef enum logic {
    MISS_IDLE = 1'b0,
    MISS_WAIT = 1'b1
  } miss_state_e;

  typedef struct packed {
    pc_t   pc;
    inst_t ir;
  } fetch_inst_t;

  // Slot 0 holds the older instruction
  typedef struct packed {
    logic [1:0]        count;
    fetch_inst_t [1:0] slot;
  } fb_push_t;

  typedef struct packed {
    logic       en;
    cache_idx_t idx;
    cache_tag_t tag;
    line_t      data;
  } icache_wr_t;

endpackage
